//--- Makefile
VERILATOR ?= verilator
TOP := aes_dec_tb
FILELIST := src.f
FLAGS := --binary --timing --assert -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -f $(FILELIST) --top-module $(TOP)
PASS := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

lint:
	$(VERILATOR) $(LINT_FLAGS)

clean:
	rm -rf obj_dir

//--- dv/aes_dec_tb.sv
`timescale 1ns/1ns

module aes_dec_tb;

	localparam aes_pkg::aes_key_t KEY_1 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_pkg::aes_block_t CT_1 = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam aes_pkg::aes_block_t PT_1 = 128'h3243f6a8885a308d313198a2e0370734;
	localparam aes_pkg::aes_key_t KEY_2 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_pkg::aes_block_t CT_2 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aes_pkg::aes_block_t PT_2 = 128'h00112233445566778899aabbccddeeff;

	localparam int SEGMENTS = 4;
	localparam int SEG_BLOCKS = 6;
	localparam int NUM_BLOCKS = 4 + SEGMENTS * SEG_BLOCKS;
	localparam int NUM_KEYS = 2 + SEGMENTS;
	localparam int MAX_CYCLES = 20 * (NUM_BLOCKS * 15 + NUM_KEYS * 11);

	logic clk;
	logic reset;
	logic key_valid;
	aes_pkg::aes_key_t key;
	logic key_ready;
	logic in_valid;
	aes_pkg::aes_block_t ciphertext;
	logic in_ready;
	logic out_valid;
	aes_pkg::aes_block_t plaintext;
	logic out_ready;

	int errors;
	int checks;
	int cycle;
	int timeout_cycles;
	int key_accepts;
	int block_accepts;
	int results;
	int expand_left;
	int acc_cycle;
	int loaded_key_id;
	logic key_seen;
	logic lat_mode;
	logic bp_mode;
	logic prev_ov;
	logic prev_or;
	aes_pkg::aes_block_t prev_pt;
	logic [31:0] seed;

	aes_pkg::aes_block_t exp_q [$];

	aes_dec_top dut (
		.clk(clk),
		.reset(reset),
		.key_valid(key_valid),
		.key(key),
		.key_ready(key_ready),
		.in_valid(in_valid),
		.ciphertext(ciphertext),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.plaintext(plaintext),
		.out_ready(out_ready)
	);

	always #50 clk = ~clk;

	function automatic int next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'(seed[30:16]);
	endfunction

	task automatic check_value(input string name, input aes_pkg::aes_block_t exp,
			input aes_pkg::aes_block_t act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// all sampling happens before the DUT registers update
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (!reset) begin
			if (!key_seen) begin
				check_flag("reset_in_ready", 1'b0, in_ready);
				check_flag("reset_out_valid", 1'b0, out_valid);
			end
			if (expand_left > 0) begin
				check_flag("expand_key_ready", 1'b0, key_ready);
				check_flag("expand_in_ready", 1'b0, in_ready);
				expand_left = expand_left - 1;
				if (expand_left == 0)
					key_seen = 1'b1;
			end
			if (key_valid && key_ready) begin
				key_accepts = key_accepts + 1;
				expand_left = 11;
			end
			if (in_valid && in_ready) begin
				block_accepts = block_accepts + 1;
				acc_cycle = cycle;
				exp_q.push_back(loaded_key_id == 1 ? PT_1 : PT_2);
			end
			// out_valid went high one edge before it is first seen here
			if (lat_mode && out_valid && !prev_ov)
				check_count("latency", 15, cycle - 1 - acc_cycle);
			if (prev_ov && !prev_or) begin
				check_flag("hold_out_valid", 1'b1, out_valid);
				check_value("hold_plaintext", prev_pt, plaintext);
			end
			// full buffer that is not emptying blocks new input
			if (out_valid && !out_ready)
				check_flag("stall_in_ready", 1'b0, in_ready);
			if (out_valid && out_ready) begin
				results = results + 1;
				if (exp_q.size() == 0) begin
					errors++;
					$display("output transfer with no block outstanding");
				end else begin
					check_value("result_order", exp_q[0], plaintext);
					void'(exp_q.pop_front());
				end
			end
		end
		prev_ov <= out_valid;
		prev_or <= out_ready;
		prev_pt <= plaintext;
	end

	always @(posedge clk) begin
		timeout_cycles = timeout_cycles + 1;
		if (timeout_cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// random stalls only while the back-pressure phase runs
	always @(negedge clk) begin
		if (bp_mode)
			out_ready = (next_random() % 3) != 0;
		else
			out_ready = 1'b1;
	end

	task automatic load_key(input aes_pkg::aes_key_t k, input int id);
		int n;
		n = key_accepts;
		key = k;
		key_valid = 1'b1;
		while (key_accepts == n)
			@(negedge clk);
		key_valid = 1'b0;
		loaded_key_id = id;
		while (expand_left != 0)
			@(negedge clk);
	endtask

	task automatic send_block(input aes_pkg::aes_block_t ct);
		int n;
		n = block_accepts;
		ciphertext = ct;
		in_valid = 1'b1;
		while (block_accepts == n)
			@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || out_valid)
			@(negedge clk);
	endtask

	task automatic known_answer(input aes_pkg::aes_key_t k, input int id,
			input aes_pkg::aes_block_t ct);
		load_key(k, id);
		repeat (2) begin
			send_block(ct);
			drain();
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		key_valid = 1'b0;
		key = '0;
		in_valid = 1'b0;
		ciphertext = '0;
		out_ready = 1'b1;
		errors = 0;
		checks = 0;
		cycle = 0;
		timeout_cycles = 0;
		key_accepts = 0;
		block_accepts = 0;
		results = 0;
		expand_left = 0;
		acc_cycle = 0;
		loaded_key_id = 0;
		key_seen = 1'b0;
		lat_mode = 1'b0;
		bp_mode = 1'b0;
		prev_ov = 1'b0;
		prev_or = 1'b0;
		prev_pt = '0;
		seed = 32'd10901;

		repeat (3) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		check_flag("reset_key_ready", 1'b1, key_ready);

		lat_mode = 1'b1;
		known_answer(KEY_1, 1, CT_1);
		known_answer(KEY_2, 2, CT_2);
		lat_mode = 1'b0;

		// alternate keys, blocks with idle gaps under stalls
		bp_mode = 1'b1;
		for (int s = 0; s < SEGMENTS; s++) begin
			if (s % 2 == 0)
				load_key(KEY_1, 1);
			else
				load_key(KEY_2, 2);
			for (int b = 0; b < SEG_BLOCKS; b++) begin
				repeat (next_random() % 4) @(negedge clk);
				send_block(s % 2 == 0 ? CT_1 : CT_2);
			end
			drain();
		end
		bp_mode = 1'b0;

		check_count("results_received", NUM_BLOCKS, results);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- source/aes_block_ctrl.sv
`timescale 1ns/1ns

module aes_block_ctrl (
	input logic clk,
	input logic reset,

	input logic in_valid,
	input aes_pkg::aes_block_t ciphertext,
	output logic in_ready,

	input logic key_loaded,
	input logic busy,

	output logic start,
	output aes_pkg::aes_block_t block_in,

	input logic done,
	input aes_pkg::aes_block_t block_out,

	output logic out_valid,
	output aes_pkg::aes_block_t plaintext,
	input logic out_ready
);

	logic accept;

	// buffer must be free by the time the admitted block finishes
	assign in_ready = key_loaded && !busy && !start && (!out_valid || out_ready);
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			block_in <= ciphertext;
	end

	// output buffer
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			if (done)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (done)
			plaintext <= block_out;
	end

endmodule

//--- source/aes_dec_top.sv
`timescale 1ns/1ns

module aes_dec_top (
	input logic clk,
	input logic reset,

	input logic key_valid,
	input aes_pkg::aes_key_t key,
	output logic key_ready,

	input logic in_valid,
	input aes_pkg::aes_block_t ciphertext,
	output logic in_ready,

	output logic out_valid,
	output aes_pkg::aes_block_t plaintext,
	input logic out_ready
);

	logic key_loaded;
	logic start;
	logic done;
	logic busy;

	aes_pkg::aes_round_t round_key_no;
	aes_pkg::aes_key_t round_key;
	aes_pkg::aes_block_t block_in;
	aes_pkg::aes_block_t block_out;

	aes_key_schedule u_key_schedule (
		.clk(clk),
		.reset(reset),
		.key_valid(key_valid),
		.key(key),
		.key_ready(key_ready),
		.key_loaded(key_loaded),
		.round_key_no(round_key_no),
		.round_key(round_key)
	);

	aes_decipher u_decipher (
		.clk(clk),
		.reset(reset),
		.start(start),
		.block_in(block_in),
		.round_key(round_key),
		.round_key_no(round_key_no),
		.block_out(block_out),
		.done(done),
		.busy(busy)
	);

	aes_block_ctrl u_block_ctrl (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.ciphertext(ciphertext),
		.in_ready(in_ready),
		.key_loaded(key_loaded),
		.busy(busy),
		.start(start),
		.block_in(block_in),
		.done(done),
		.block_out(block_out),
		.out_valid(out_valid),
		.plaintext(plaintext),
		.out_ready(out_ready)
	);

endmodule

//--- source/aes_decipher.sv
`timescale 1ns/1ns

module aes_decipher (
	input logic clk,
	input logic reset,
	input logic start,
	input aes_pkg::aes_block_t block_in,
	input aes_pkg::aes_key_t round_key,
	output aes_pkg::aes_round_t round_key_no,
	output aes_pkg::aes_block_t block_out,
	output logic done,
	output logic busy
);

	logic read_en;
	logic read_en_d;
	logic round_en;
	logic first_round;
	logic last_round;

	aes_pkg::aes_round_t round_no;
	aes_pkg::aes_key_t key_q;

	aes_pkg::aes_block_t after_sub;
	aes_pkg::aes_block_t after_key;
	aes_pkg::aes_block_t after_mix;

	always_comb begin
		after_sub = aes_pkg::inv_sub_bytes(aes_pkg::inv_shift_rows(block_out));
		after_key = after_sub ^ key_q;
		after_mix = aes_pkg::inv_mix_cols(after_key);
	end

	// key index walks down from round 10
	always_ff @(posedge clk) begin
		if (reset) begin
			read_en <= 1'b0;
			read_en_d <= 1'b0;
			round_en <= 1'b0;
			round_key_no <= '0;
		end else begin
			read_en_d <= read_en;
			round_en <= read_en_d;
			if (start) begin
				read_en <= 1'b1;
				round_key_no <= aes_pkg::NR;
			end else if (round_key_no != '0) begin
				read_en <= 1'b1;
				round_key_no <= round_key_no - 4'd1;
			end else begin
				read_en <= 1'b0;
			end
		end
	end

	// key is valid at the input one cycle after its index
	always_ff @(posedge clk) begin
		if (read_en_d)
			key_q <= round_key;
	end

	assign first_round = (round_no == '0);
	assign last_round = (round_no == aes_pkg::NR);

	always_ff @(posedge clk) begin
		if (round_en) begin
			if (first_round)
				block_out <= block_in ^ key_q;
			else if (last_round)
				block_out <= after_key;
			else
				block_out <= after_mix;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			round_no <= '0;
			done <= 1'b0;
			busy <= 1'b0;
		end else begin
			done <= round_en && last_round;
			if (round_en)
				round_no <= last_round ? '0 : round_no + 4'd1;
			// held through the done cycle
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

endmodule

//--- source/aes_key_schedule.sv
`timescale 1ns/1ns

module aes_key_schedule (
	input logic clk,
	input logic reset,
	input logic key_valid,
	input aes_pkg::aes_key_t key,
	output logic key_ready,
	output logic key_loaded,
	input aes_pkg::aes_round_t round_key_no,
	output aes_pkg::aes_key_t round_key
);

	typedef enum logic [1:0] {
		idle,
		expand,
		loaded
	} state_t;

	state_t state;
	state_t state_next;

	logic key_accept;
	aes_pkg::aes_round_t wr_idx;
	aes_pkg::aes_key_t work_key;
	aes_pkg::aes_key_t next_key;
	aes_pkg::aes_word_t temp;

	aes_pkg::aes_key_t keys [0:aes_pkg::NR];

	assign key_accept = key_valid && key_ready;
	assign key_loaded = (state == loaded);

	always_comb begin
		state_next = state;
		case (state)
			idle, loaded: begin
				if (key_accept)
					state_next = expand;
			end
			expand: begin
				if (wr_idx == aes_pkg::NR)
					state_next = loaded;
			end
			default: state_next = idle;
		endcase
	end

	// next round key from the one being written
	always_comb begin
		temp = aes_pkg::sub_word(aes_pkg::rot_word(work_key[31:0])) ^
			aes_pkg::rcon(wr_idx + 4'd1);
		next_key[127:96] = work_key[127:96] ^ temp;
		next_key[95:64] = work_key[95:64] ^ next_key[127:96];
		next_key[63:32] = work_key[63:32] ^ next_key[95:64];
		next_key[31:0] = work_key[31:0] ^ next_key[63:32];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			key_ready <= 1'b0;
			wr_idx <= '0;
		end else begin
			state <= state_next;
			key_ready <= (state_next != expand);
			if (key_accept)
				wr_idx <= '0;
			else if (state == expand)
				wr_idx <= wr_idx + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (key_accept) begin
			work_key <= key;
		end else if (state == expand) begin
			keys[wr_idx] <= work_key;
			work_key <= next_key;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		round_key <= keys[round_key_no];
	end

endmodule

//--- source/aes_pkg.sv
package aes_pkg;

	localparam int BLOCK_W = 128;
	localparam int KEY_W = 128;
	localparam int WORD_W = 32;
	localparam int ROUND_W = 4;

	// byte 0 sits in the most significant position
	typedef logic [BLOCK_W-1:0] aes_block_t;
	typedef logic [KEY_W-1:0] aes_key_t;
	typedef logic [WORD_W-1:0] aes_word_t;
	typedef logic [ROUND_W-1:0] aes_round_t;

	localparam aes_round_t NR = 4'd10;

	// entry 0 is the leftmost byte
	localparam logic [0:255][7:0] sbox = {
		256'h637c777bf26b6fc53001672bfed7ab76_ca82c97dfa5947f0add4a2af9ca472c0,
		256'hb7fd9326363ff7cc34a5e5f171d83115_04c723c31896059a071280e2eb27b275,
		256'h09832c1a1b6e5aa0523bd6b329e32f84_53d100ed20fcb15b6acbbe394a4c58cf,
		256'hd0efaafb434d338545f9027f503c9fa8_51a3408f929d38f5bcb6da2110fff3d2,
		256'hcd0c13ec5f974417c4a77e3d645d1973_60814fdc222a908846eeb814de5e0bdb,
		256'he0323a0a4906245cc2d3ac629195e479_e7c8376d8dd54ea96c56f4ea657aae08,
		256'hba78252e1ca6b4c6e8dd741f4bbd8b8a_703eb5664803f60e613557b986c11d9e,
		256'he1f8981169d98e949b1e87e9ce5528df_8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] inv_sbox = {
		256'h52096ad53036a538bf40a39e81f3d7fb_7ce339829b2fff87348e4344c4dee9cb,
		256'h547b9432a6c2233dee4c950b42fac34e_082ea16628d924b2765ba2496d8bd125,
		256'h72f8f66486689816d4a45ccc5d65b692_6c704850fdedb9da5e154657a78d9d84,
		256'h90d8ab008cbcd30af7e45805b8b34506_d02c1e8fca3f0f02c1afbd0301138a6b,
		256'h3a9111414f67dcea97f2cfcef0b4e673_96ac7422e7ad3585e2f937e81c75df6e,
		256'h47f11a711d29c5896fb7620eaa18be1b_fc563e4bc6d279209adbc0fe78cd5af4,
		256'h1fdda8338807c731b11210592780ec5f_60517fa919b54a0d2de57a9f93c99cef,
		256'ha0e03b4dae2af5b0c8ebbb3c83539961_172b047eba77d626e169146355210c7d
	};

	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	// multiply by a 4-bit constant in GF(2^8)
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] m);
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		x2 = xtime(a);
		x4 = xtime(x2);
		x8 = xtime(x4);
		return (m[0] ? a : 8'h00) ^ (m[1] ? x2 : 8'h00) ^
			(m[2] ? x4 : 8'h00) ^ (m[3] ? x8 : 8'h00);
	endfunction

	function automatic aes_block_t inv_shift_rows(input aes_block_t b);
		aes_block_t s;
		int src;
		// row r of column c comes from column c - r
		for (int i = 0; i < 16; i++) begin
			src = (i % 4) + 4 * (((i / 4) - (i % 4) + 4) % 4);
			s[127 - 8 * i -: 8] = b[127 - 8 * src -: 8];
		end
		return s;
	endfunction

	function automatic aes_block_t inv_sub_bytes(input aes_block_t b);
		aes_block_t s;
		for (int i = 0; i < 16; i++) begin
			s[8 * i +: 8] = inv_sbox[b[8 * i +: 8]];
		end
		return s;
	endfunction

	function automatic aes_word_t inv_mix_col(input aes_word_t w);
		logic [7:0] s0;
		logic [7:0] s1;
		logic [7:0] s2;
		logic [7:0] s3;
		logic [7:0] r0;
		logic [7:0] r1;
		logic [7:0] r2;
		logic [7:0] r3;
		s0 = w[31:24];
		s1 = w[23:16];
		s2 = w[15:8];
		s3 = w[7:0];
		r0 = gf_mul(s0, 4'he) ^ gf_mul(s1, 4'hb) ^ gf_mul(s2, 4'hd) ^ gf_mul(s3, 4'h9);
		r1 = gf_mul(s0, 4'h9) ^ gf_mul(s1, 4'he) ^ gf_mul(s2, 4'hb) ^ gf_mul(s3, 4'hd);
		r2 = gf_mul(s0, 4'hd) ^ gf_mul(s1, 4'h9) ^ gf_mul(s2, 4'he) ^ gf_mul(s3, 4'hb);
		r3 = gf_mul(s0, 4'hb) ^ gf_mul(s1, 4'hd) ^ gf_mul(s2, 4'h9) ^ gf_mul(s3, 4'he);
		return {r0, r1, r2, r3};
	endfunction

	function automatic aes_block_t inv_mix_cols(input aes_block_t b);
		aes_block_t s;
		for (int c = 0; c < 4; c++) begin
			s[127 - 32 * c -: 32] = inv_mix_col(b[127 - 32 * c -: 32]);
		end
		return s;
	endfunction

	function automatic aes_word_t sub_word(input aes_word_t w);
		aes_word_t s;
		for (int i = 0; i < 4; i++) begin
			s[8 * i +: 8] = sbox[w[8 * i +: 8]];
		end
		return s;
	endfunction

	function automatic aes_word_t rot_word(input aes_word_t w);
		return {w[23:0], w[31:24]};
	endfunction

	function automatic aes_word_t rcon(input aes_round_t i);
		logic [7:0] rc;
		case (i)
			4'd1: rc = 8'h01;
			4'd2: rc = 8'h02;
			4'd3: rc = 8'h04;
			4'd4: rc = 8'h08;
			4'd5: rc = 8'h10;
			4'd6: rc = 8'h20;
			4'd7: rc = 8'h40;
			4'd8: rc = 8'h80;
			4'd9: rc = 8'h1b;
			4'd10: rc = 8'h36;
			default: rc = 8'h00;
		endcase
		return {rc, 24'h000000};
	endfunction

endpackage

//--- src.f
source/aes_pkg.sv
source/aes_key_schedule.sv
source/aes_decipher.sv
source/aes_block_ctrl.sv
source/aes_dec_top.sv
dv/aes_dec_tb.sv
